// ==== include/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// serial bit period in clock cycles
// kept short for simulation
`define UART_CLKS_PER_BIT 8

// fifo depths
`define UART_TX_DEPTH 8
`define UART_RX_DEPTH 8

// status thresholds in entries
`define UART_ALMOST_EMPTY 1
`define UART_ALMOST_FULL 6

`endif

// ==== design/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // one serial data byte
    typedef logic [7:0] byte_t;

    // receive fifo entry, stop bit status above the data
    typedef struct packed {
        logic  frame_err;
        byte_t data;
    } rx_word_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_FETCH,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int  DEPTH              = 8,
    parameter int  ALMOST_EMPTY_COUNT = 1,
    parameter int  ALMOST_FULL_COUNT  = DEPTH - 2,
    parameter type payload_t          = logic [7:0]
) (
    input  wire logic     clk_i,
    input  wire logic     reset_i,

    // write side
    input  wire payload_t write_data_i,
    input  wire logic     write_enable_i,

    // read side
    input  wire logic     read_enable_i,
    output payload_t      read_data_o,
    output logic          read_valid_o,

    // status
    output logic          fifo_empty_o,
    output logic          fifo_almost_empty_o,
    output logic          fifo_almost_full_o,
    output logic          fifo_full_o,
    output logic          write_drop_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // one extra bit so a full buffer differs from an empty one
    localparam int CNT_W = PTR_W + 1;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    localparam ptr_t   LAST_PTR       = ptr_t'(DEPTH - 1);
    localparam count_t C_DEPTH        = count_t'(DEPTH);
    localparam count_t C_ALMOST_EMPTY = count_t'(ALMOST_EMPTY_COUNT);
    localparam count_t C_ALMOST_FULL  = count_t'(ALMOST_FULL_COUNT);

    payload_t mem_r [DEPTH];
    ptr_t     wr_ptr_r;
    ptr_t     rd_ptr_r;
    count_t   count_r;
    count_t   count_w;
    logic     do_write;
    logic     do_read;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == LAST_PTR) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // flags are registered, so these see last cycle's status
    assign do_write = write_enable_i && !fifo_full_o;
    assign do_read  = read_enable_i && !fifo_empty_o;

    always_comb begin
        count_w = count_r;
        if (do_write && !do_read) begin
            count_w = count_r + 1'b1;
        end else if (do_read && !do_write) begin
            count_w = count_r - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_r            <= '0;
            rd_ptr_r            <= '0;
            count_r             <= '0;
            read_valid_o        <= 1'b0;
            write_drop_o        <= 1'b0;
            fifo_empty_o        <= 1'b1;
            fifo_almost_empty_o <= 1'b1;
            fifo_almost_full_o  <= 1'b0;
            fifo_full_o         <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr_r <= next_ptr(wr_ptr_r);
            end
            if (do_read) begin
                rd_ptr_r <= next_ptr(rd_ptr_r);
            end
            count_r      <= count_w;
            read_valid_o <= do_read;
            write_drop_o <= write_enable_i && fifo_full_o;

            // status from the next count
            fifo_empty_o        <= (count_w == '0);
            fifo_almost_empty_o <= (count_w <= C_ALMOST_EMPTY);
            fifo_almost_full_o  <= (count_w >= C_ALMOST_FULL);
            fifo_full_o         <= (count_w == C_DEPTH);
        end
    end

    // storage and read data
    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem_r[wr_ptr_r] <= write_data_i;
        end
        if (do_read) begin
            read_data_o <= mem_r[rd_ptr_r];
        end
    end

endmodule

`default_nettype wire

// ==== design/baud_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module baud_timer #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire logic clk_i,
    input  wire logic reset_i,
    input  wire logic start_i,
    output logic      mid_o,
    output logic      bit_o
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef logic [CNT_W-1:0] count_t;

    localparam count_t MID_COUNT  = count_t'(CLKS_PER_BIT / 2 - 1);
    localparam count_t LAST_COUNT = count_t'(CLKS_PER_BIT - 1);

    count_t count_r;

    // wraps every bit period, start_i realigns it to a new frame
    always_ff @(posedge clk_i) begin
        if (reset_i || start_i) begin
            count_r <= '0;
        end else if (count_r == LAST_COUNT) begin
            count_r <= '0;
        end else begin
            count_r <= count_r + 1'b1;
        end
    end

    assign mid_o = (count_r == MID_COUNT);
    assign bit_o = (count_r == LAST_COUNT);

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  reset_i,

    // transmit fifo
    input  wire logic  fifo_empty_i,
    input  wire byte_t fifo_data_i,
    input  wire logic  fifo_valid_i,
    output logic       fifo_read_o,

    // baud timer
    input  wire logic  bit_i,
    output logic       timer_start_o,

    output logic       tx_o,
    output logic       busy_o
);

    tx_state_t  state_r;
    byte_t      shift_r;
    logic [2:0] bit_cnt_r;

    assign fifo_read_o   = (state_r == TX_IDLE) && !fifo_empty_i;
    // start bit begins with the load, so the timer restarts there
    assign timer_start_o = (state_r == TX_FETCH) && fifo_valid_i;
    assign busy_o        = (state_r != TX_IDLE);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r   <= TX_IDLE;
            tx_o      <= 1'b1;
            bit_cnt_r <= '0;
        end else begin
            case (state_r)
                TX_IDLE: begin
                    if (!fifo_empty_i) begin
                        state_r <= TX_FETCH;
                    end
                end
                TX_FETCH: begin
                    if (fifo_valid_i) begin
                        state_r <= TX_START;
                        tx_o    <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_i) begin
                        state_r   <= TX_DATA;
                        tx_o      <= shift_r[0];
                        bit_cnt_r <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_i) begin
                        if (bit_cnt_r == 3'd7) begin
                            state_r <= TX_STOP;
                            tx_o    <= 1'b1;
                        end else begin
                            tx_o      <= shift_r[0];
                            bit_cnt_r <= bit_cnt_r + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_i) begin
                        state_r <= TX_IDLE;
                    end
                end
                default: begin
                    state_r <= TX_IDLE;
                    tx_o    <= 1'b1;
                end
            endcase
        end
    end

    // lsb first, next bit always sits in shift_r[0]
    always_ff @(posedge clk_i) begin
        if (timer_start_o) begin
            shift_r <= fifo_data_i;
        end else if (bit_i && (state_r == TX_START || state_r == TX_DATA)) begin
            shift_r <= shift_r >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic reset_i,
    input  wire logic rx_i,

    // baud timer
    input  wire logic mid_i,
    input  wire logic bit_i,
    output logic      timer_start_o,

    // receive fifo
    output rx_word_t  word_o,
    output logic      word_write_o
);

    rx_state_t  state_r;
    logic       meta_r;
    logic       sync_r;
    logic       prev_r;
    byte_t      shift_r;
    logic [2:0] bit_cnt_r;
    logic       fall_edge;

    // two flop synchronizer plus one delay for edge detect
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            meta_r <= 1'b1;
            sync_r <= 1'b1;
            prev_r <= 1'b1;
        end else begin
            meta_r <= rx_i;
            sync_r <= meta_r;
            prev_r <= sync_r;
        end
    end

    assign fall_edge     = prev_r && !sync_r;
    assign timer_start_o = (state_r == RX_IDLE) && fall_edge;

    // word goes out at the stop bit sample
    assign word_write_o     = (state_r == RX_STOP) && mid_i;
    assign word_o.frame_err = !sync_r;
    assign word_o.data      = shift_r;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r   <= RX_IDLE;
            bit_cnt_r <= '0;
        end else begin
            case (state_r)
                RX_IDLE: begin
                    if (fall_edge) begin
                        state_r <= RX_START;
                    end
                end
                RX_START: begin
                    // line back high at mid start bit means a glitch
                    if (mid_i && sync_r) begin
                        state_r <= RX_IDLE;
                    end else if (bit_i) begin
                        state_r   <= RX_DATA;
                        bit_cnt_r <= '0;
                    end
                end
                RX_DATA: begin
                    if (bit_i) begin
                        if (bit_cnt_r == 3'd7) begin
                            state_r <= RX_STOP;
                        end else begin
                            bit_cnt_r <= bit_cnt_r + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (mid_i) begin
                        state_r <= RX_IDLE;
                    end
                end
                default: begin
                    state_r <= RX_IDLE;
                end
            endcase
        end
    end

    // lsb arrives first and ends up in bit 0
    always_ff @(posedge clk_i) begin
        if (state_r == RX_DATA && mid_i) begin
            shift_r <= {sync_r, shift_r[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== design/uart_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_core
    import uart_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  reset_i,

    // host transmit side
    input  wire byte_t tx_data_i,
    input  wire logic  tx_write_i,
    output logic       tx_o,
    output logic       tx_busy_o,
    output logic       tx_full_o,
    output logic       tx_almost_full_o,

    // host receive side
    input  wire logic  rx_i,
    input  wire logic  rx_read_i,
    output byte_t      rx_data_o,
    output logic       rx_frame_err_o,
    output logic       rx_valid_o,
    output logic       rx_empty_o,
    output logic       rx_almost_empty_o,
    output logic       rx_drop_o
);

    byte_t    tx_fifo_data;
    logic     tx_empty;
    logic     tx_fifo_read;
    logic     tx_fifo_valid;
    logic     tx_timer_start;
    logic     tx_bit;

    rx_word_t rx_word;
    rx_word_t rx_read_word;
    logic     rx_word_write;
    logic     rx_timer_start;
    logic     rx_mid;
    logic     rx_bit;

    assign rx_data_o      = rx_read_word.data;
    assign rx_frame_err_o = rx_read_word.frame_err;

    sync_fifo #(
        .DEPTH              (`UART_TX_DEPTH),
        .ALMOST_EMPTY_COUNT (`UART_ALMOST_EMPTY),
        .ALMOST_FULL_COUNT  (`UART_ALMOST_FULL),
        .payload_t          (byte_t)
    ) u_tx_fifo (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .write_data_i        (tx_data_i),
        .write_enable_i      (tx_write_i),
        .read_enable_i       (tx_fifo_read),
        .read_data_o         (tx_fifo_data),
        .read_valid_o        (tx_fifo_valid),
        .fifo_empty_o        (tx_empty),
        .fifo_almost_empty_o (),
        .fifo_almost_full_o  (tx_almost_full_o),
        .fifo_full_o         (tx_full_o),
        .write_drop_o        ()
    );

    baud_timer #(
        .CLKS_PER_BIT (`UART_CLKS_PER_BIT)
    ) u_tx_timer (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .start_i (tx_timer_start),
        .mid_o   (),
        .bit_o   (tx_bit)
    );

    uart_tx u_uart_tx (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .fifo_empty_i  (tx_empty),
        .fifo_data_i   (tx_fifo_data),
        .fifo_valid_i  (tx_fifo_valid),
        .fifo_read_o   (tx_fifo_read),
        .bit_i         (tx_bit),
        .timer_start_o (tx_timer_start),
        .tx_o          (tx_o),
        .busy_o        (tx_busy_o)
    );

    baud_timer #(
        .CLKS_PER_BIT (`UART_CLKS_PER_BIT)
    ) u_rx_timer (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .start_i (rx_timer_start),
        .mid_o   (rx_mid),
        .bit_o   (rx_bit)
    );

    uart_rx u_uart_rx (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .rx_i          (rx_i),
        .mid_i         (rx_mid),
        .bit_i         (rx_bit),
        .timer_start_o (rx_timer_start),
        .word_o        (rx_word),
        .word_write_o  (rx_word_write)
    );

    // no back-pressure toward the line, overflow shows up as rx_drop_o
    sync_fifo #(
        .DEPTH              (`UART_RX_DEPTH),
        .ALMOST_EMPTY_COUNT (`UART_ALMOST_EMPTY),
        .ALMOST_FULL_COUNT  (`UART_ALMOST_FULL),
        .payload_t          (rx_word_t)
    ) u_rx_fifo (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .write_data_i        (rx_word),
        .write_enable_i      (rx_word_write),
        .read_enable_i       (rx_read_i),
        .read_data_o         (rx_read_word),
        .read_valid_o        (rx_valid_o),
        .fifo_empty_o        (rx_empty_o),
        .fifo_almost_empty_o (rx_almost_empty_o),
        .fifo_almost_full_o  (),
        .fifo_full_o         (),
        .write_drop_o        (rx_drop_o)
    );

endmodule

`default_nettype wire

// ==== sim/uart_core_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_core_chk (
    input wire logic clk_i,
    input wire logic reset_i,
    input wire logic tx_i,
    input wire logic tx_busy_i,
    input wire logic tx_full_i,
    input wire logic tx_empty_i,
    input wire logic rx_valid_i,
    input wire logic rx_drop_i
);

    // read data valid lasts one cycle per strobe
    valid_pulse_a: assert property (
        @(posedge clk_i) disable iff (reset_i) rx_valid_i |=> !rx_valid_i
    ) else $error("rx_valid_o high for more than one cycle");

    drop_pulse_a: assert property (
        @(posedge clk_i) disable iff (reset_i) rx_drop_i |=> !rx_drop_i
    ) else $error("rx_drop_o high for more than one cycle");

    // idle line is a mark
    tx_idle_high_a: assert property (
        @(posedge clk_i) disable iff (reset_i) !tx_busy_i |-> tx_i
    ) else $error("tx_o low while the transmitter is idle");

    tx_fifo_flags_a: assert property (
        @(posedge clk_i) disable iff (reset_i) !(tx_full_i && tx_empty_i)
    ) else $error("transmit FIFO full and empty at once");

endmodule

bind uart_core uart_core_chk u_uart_core_chk (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .tx_i       (tx_o),
    .tx_busy_i  (tx_busy_o),
    .tx_full_i  (tx_full_o),
    .tx_empty_i (tx_empty),
    .rx_valid_i (rx_valid_o),
    .rx_drop_i  (rx_drop_o)
);

`default_nettype wire

// ==== sim/uart_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_core_tb
    import uart_pkg::*;
();

    localparam int CPB            = `UART_CLKS_PER_BIT;
    localparam int TIMEOUT_CYCLES = 40 * CPB;
    localparam int TBL_N          = 8;

    logic  clk_i = 1'b0;
    logic  reset_i;
    byte_t tx_data_i;
    logic  tx_write_i;
    logic  rx_i;
    logic  rx_read_i;
    logic  tx_o;
    logic  tx_busy_o;
    logic  tx_full_o;
    logic  tx_almost_full_o;
    byte_t rx_data_o;
    logic  rx_frame_err_o;
    logic  rx_valid_o;
    logic  rx_empty_o;
    logic  rx_almost_empty_o;
    logic  rx_drop_o;

    logic   loopback;
    logic   inj_line;
    int     error_count = 0;
    int     stall_count = 0;
    int     drop_count = 0;
    integer seed;

    // stimulus table: byte, stop bit, expected frame error
    byte_t tbl_data [TBL_N];
    logic  tbl_stop [TBL_N];
    logic  tbl_ferr [TBL_N];
    byte_t burst [9];

    always #50 clk_i = ~clk_i;

    assign rx_i = loopback ? tx_o : inj_line;

    always @(negedge clk_i) begin
        if (!reset_i && rx_drop_o) begin
            drop_count <= drop_count + 1;
        end
    end

    uart_core u_uart_core (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .tx_data_i         (tx_data_i),
        .tx_write_i        (tx_write_i),
        .tx_o              (tx_o),
        .tx_busy_o         (tx_busy_o),
        .tx_full_o         (tx_full_o),
        .tx_almost_full_o  (tx_almost_full_o),
        .rx_i              (rx_i),
        .rx_read_i         (rx_read_i),
        .rx_data_o         (rx_data_o),
        .rx_frame_err_o    (rx_frame_err_o),
        .rx_valid_o        (rx_valid_o),
        .rx_empty_o        (rx_empty_o),
        .rx_almost_empty_o (rx_almost_empty_o),
        .rx_drop_o         (rx_drop_o)
    );

    task automatic check_byte(input byte_t actual, input byte_t expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at time %0t: %s is 0x%02h, expected 0x%02h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at time %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            error_count++;
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d stalls", error_count, stall_count);
        if (error_count == 0 && stall_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic stall(input string what);
        stall_count++;
        $display("stall: gave up after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        finish_run();
    endtask

    task automatic wait_rx_ready();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (rx_empty_o && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            cycles++;
        end
        if (rx_empty_o) begin
            stall("a received byte");
        end
    endtask

    task automatic wait_tx_busy(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (tx_busy_o !== level && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            cycles++;
        end
        if (tx_busy_o !== level) begin
            stall("the transmitter busy level");
        end
    endtask

    task automatic wait_tx_not_full();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (tx_full_o && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            cycles++;
        end
        if (tx_full_o) begin
            stall("the transmit FIFO to drain");
        end
    endtask

    // start bit, eight data bits lsb first, stop bit, one idle bit
    task automatic send_frame(input byte_t data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk_i);
            inj_line <= (i < 10) ? frame[0] : 1'b1;
            frame = frame >> 1;
            repeat (CPB - 1) @(posedge clk_i);
        end
    endtask

    task automatic pop_and_check(input byte_t exp_data, input logic exp_ferr);
        wait_rx_ready();
        @(posedge clk_i);
        rx_read_i <= 1'b1;
        @(posedge clk_i);
        rx_read_i <= 1'b0;
        @(negedge clk_i);
        check_flag(rx_valid_o, 1'b1, "rx_valid_o after read");
        check_byte(rx_data_o, exp_data, "rx_data_o");
        check_flag(rx_frame_err_o, exp_ferr, "rx_frame_err_o");
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        tbl_data[0] = 8'h55;
        tbl_stop[0] = 1'b1;
        tbl_data[1] = 8'hA3;
        tbl_stop[1] = 1'b0;
        tbl_data[2] = 8'h00;
        tbl_stop[2] = 1'b1;
        tbl_data[3] = 8'hFF;
        tbl_stop[3] = 1'b0;
        for (int i = 4; i < TBL_N; i++) begin
            rnd = $random(seed);
            tbl_data[i] = rnd[7:0];
            tbl_stop[i] = rnd[8];
        end
        for (int i = 0; i < TBL_N; i++) begin
            // a low stop bit is a framing error
            tbl_ferr[i] = !tbl_stop[i];
            burst[i] = tbl_data[i] ^ 8'h5A;
        end
        burst[8] = 8'hC3;
    endtask

    initial begin
        int held;
        seed = 32'h2388;
        reset_i = 1'b1;
        tx_data_i = '0;
        tx_write_i = 1'b0;
        rx_read_i = 1'b0;
        loopback = 1'b1;
        inj_line = 1'b1;
        build_table();
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;

        @(negedge clk_i);
        check_flag(tx_o, 1'b1, "tx_o after reset");
        check_flag(tx_busy_o, 1'b0, "tx_busy_o after reset");
        check_flag(tx_full_o, 1'b0, "tx_full_o after reset");
        check_flag(tx_almost_full_o, 1'b0, "tx_almost_full_o after reset");
        check_flag(rx_empty_o, 1'b1, "rx_empty_o after reset");
        check_flag(rx_almost_empty_o, 1'b1, "rx_almost_empty_o after reset");
        check_flag(rx_valid_o, 1'b0, "rx_valid_o after reset");
        check_flag(rx_drop_o, 1'b0, "rx_drop_o after reset");
        @(posedge clk_i);
        rx_read_i <= 1'b1;
        @(posedge clk_i);
        rx_read_i <= 1'b0;
        @(negedge clk_i);
        check_flag(rx_valid_o, 1'b0, "rx_valid_o on empty read");

        // loopback of the table bytes
        for (int i = 0; i < TBL_N; i++) begin
            @(posedge clk_i);
            tx_write_i <= 1'b1;
            tx_data_i  <= tbl_data[i];
        end
        @(posedge clk_i);
        tx_write_i <= 1'b0;
        for (int i = 0; i < TBL_N; i++) begin
            pop_and_check(tbl_data[i], 1'b0);
        end

        // fill the transmit FIFO behind a frame in flight
        wait_tx_busy(1'b0);
        @(posedge clk_i);
        tx_write_i <= 1'b1;
        tx_data_i  <= 8'h96;
        @(posedge clk_i);
        tx_write_i <= 1'b0;
        wait_tx_busy(1'b1);
        for (int k = 0; k <= 8; k++) begin
            @(posedge clk_i);
            tx_write_i <= 1'b1;
            tx_data_i  <= burst[k];
            @(negedge clk_i);
            held = (k < `UART_TX_DEPTH) ? k : `UART_TX_DEPTH;
            check_flag(tx_almost_full_o, held >= `UART_ALMOST_FULL, "tx_almost_full_o in burst");
            check_flag(tx_full_o, held >= `UART_TX_DEPTH, "tx_full_o in burst");
        end
        @(posedge clk_i);
        tx_write_i <= 1'b0;
        @(negedge clk_i);
        check_flag(tx_full_o, 1'b1, "tx_full_o after burst");
        wait_tx_not_full();
        check_flag(tx_almost_full_o, 1'b1, "tx_almost_full_o after first pop");
        pop_and_check(8'h96, 1'b0);
        for (int k = 0; k < 8; k++) begin
            pop_and_check(burst[k], 1'b0);
        end
        repeat (15 * CPB) @(negedge clk_i);
        check_flag(rx_empty_o, 1'b1, "rx_empty_o after burst");

        // injected frames, stop bit from the table
        @(posedge clk_i);
        loopback <= 1'b0;
        for (int i = 0; i < TBL_N; i++) begin
            send_frame(tbl_data[i], tbl_stop[i]);
            pop_and_check(tbl_data[i], tbl_ferr[i]);
        end

        // overrun the receive FIFO by one frame
        for (int i = 0; i <= 8; i++) begin
            send_frame(burst[i], 1'b1);
        end
        check_count(drop_count, 1, "rx_drop_o pulses");
        for (int i = 0; i < `UART_RX_DEPTH; i++) begin
            @(negedge clk_i);
            check_flag(rx_almost_empty_o, (`UART_RX_DEPTH - i) <= `UART_ALMOST_EMPTY,
                       "rx_almost_empty_o while draining");
            pop_and_check(burst[i], 1'b0);
        end
        check_flag(rx_empty_o, 1'b1, "rx_empty_o after drain");
        check_flag(rx_almost_empty_o, 1'b1, "rx_almost_empty_o after drain");
        finish_run();
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
design/uart_pkg.sv
design/sync_fifo.sv
design/baud_timer.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_core.sv
sim/uart_core_chk.sv
sim/uart_core_tb.sv

// ==== Makefile ====
TOP := uart_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
